/* soc_pkg.sv */
package soc_pkg;

    // bus widths
    typedef logic [31:0] wb_adr_t;
    typedef logic [7:0]  wb_dat_t;

    // local address forwarded to each device
    typedef logic [15:0] dev_adr_t;

    // device chosen by the decoder for one access
    typedef enum logic [1:0] {
        DEV_RAM,
        DEV_TIMER,
        DEV_PRNG,
        DEV_LEDS
    } dev_sel_e;

    // address map, a device claims an address when (adr & MASK) == BASE
    localparam wb_adr_t TIMER_BASE = 32'hFFFF_FD00;
    localparam wb_adr_t TIMER_MASK = 32'hFFFF_FF00;
    localparam wb_adr_t PRNG_BASE  = 32'hFFFF_FE00;
    localparam wb_adr_t PRNG_MASK  = 32'hFFFF_FF00;
    localparam wb_adr_t LEDS_BASE  = 32'hFFFF_FFF0;
    localparam wb_adr_t LEDS_MASK  = 32'hFFFF_FFF0;

    // timer register offsets
    typedef enum logic [1:0] {
        TMR_RELOAD_LO = 2'd0,
        TMR_RELOAD_HI = 2'd1,
        TMR_CTRL      = 2'd2,
        TMR_PENDING   = 2'd3
    } timer_reg_e;

    // galois lfsr state and feedback
    typedef logic [31:0] lfsr_t;
    localparam lfsr_t PRNG_TAPS = 32'h8020_0003;

endpackage

/* wb8_if.sv */
interface wb8_if import soc_pkg::*; ();

    // request side, driven by the decoder
    logic     stb;
    logic     we;
    dev_adr_t adr;
    wb_dat_t  dat_w;

    // response side, driven by the device
    wb_dat_t  dat_r;
    logic     ack;

    modport master (
        output stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

/* reset_sequencer.sv */
module reset_sequencer #(
    parameter int RESET_CYCLES = 16
) (
    input  logic clk,
    input  logic reset_i,
    input  logic reset_button_n_i,
    output logic soc_reset_o
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    // starts loaded so the soc comes up in reset after configuration
    logic [CNT_W-1:0] count_q = CNT_W'(RESET_CYCLES);
    logic             request;

    // external reset or the button, both restart the count
    assign request = reset_i | ~reset_button_n_i;

    always_ff @(posedge clk) begin
        if (request) begin
            count_q <= CNT_W'(RESET_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - CNT_W'(1);
        end
    end

    // held until the counter has run down
    assign soc_reset_o = (count_q != '0);

endmodule

/* wb_decoder.sv */
module wb_decoder import soc_pkg::*; (
    input  logic    clk,
    input  logic    soc_reset_i,
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  wb_dat_t wb_dat_i,
    output wb_dat_t wb_dat_o,
    output logic    wb_ack_o,
    wb8_if.master   ram_bus,
    wb8_if.master   timer_bus,
    wb8_if.master   prng_bus,
    wb8_if.master   leds_bus
);

    dev_sel_e sel;
    dev_sel_e ret_sel_q;
    logic     req;

    // address map, ram takes whatever nobody else claims
    always_comb begin
        if ((wb_adr_i & LEDS_MASK) == LEDS_BASE) begin
            sel = DEV_LEDS;
        end else if ((wb_adr_i & PRNG_MASK) == PRNG_BASE) begin
            sel = DEV_PRNG;
        end else if ((wb_adr_i & TIMER_MASK) == TIMER_BASE) begin
            sel = DEV_TIMER;
        end else begin
            sel = DEV_RAM;
        end
    end

    // no device sees a strobe while the soc is held in reset
    assign req = wb_cyc_i & wb_stb_i & ~soc_reset_i;

    assign ram_bus.stb   = req & (sel == DEV_RAM);
    assign timer_bus.stb = req & (sel == DEV_TIMER);
    assign prng_bus.stb  = req & (sel == DEV_PRNG);
    assign leds_bus.stb  = req & (sel == DEV_LEDS);

    // shared request fields go to every device
    assign ram_bus.we      = wb_we_i;
    assign ram_bus.adr     = wb_adr_i[15:0];
    assign ram_bus.dat_w   = wb_dat_i;
    assign timer_bus.we    = wb_we_i;
    assign timer_bus.adr   = wb_adr_i[15:0];
    assign timer_bus.dat_w = wb_dat_i;
    assign prng_bus.we     = wb_we_i;
    assign prng_bus.adr    = wb_adr_i[15:0];
    assign prng_bus.dat_w  = wb_dat_i;
    assign leds_bus.we     = wb_we_i;
    assign leds_bus.adr    = wb_adr_i[15:0];
    assign leds_bus.dat_w  = wb_dat_i;

    // ack comes one clock after stb, so follow the device strobed last
    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            ret_sel_q <= DEV_RAM;
        end else if (req) begin
            ret_sel_q <= sel;
        end
    end

    always_comb begin
        case (ret_sel_q)
            DEV_TIMER: begin
                wb_dat_o = timer_bus.dat_r;
                wb_ack_o = timer_bus.ack;
            end
            DEV_PRNG: begin
                wb_dat_o = prng_bus.dat_r;
                wb_ack_o = prng_bus.ack;
            end
            DEV_LEDS: begin
                wb_dat_o = leds_bus.dat_r;
                wb_ack_o = leds_bus.ack;
            end
            default: begin
                wb_dat_o = ram_bus.dat_r;
                wb_ack_o = ram_bus.ack;
            end
        endcase
    end

endmodule

/* led_port.sv */
module led_port import soc_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    wb8_if.slave    bus,
    output wb_dat_t leds_o
);

    wb_dat_t leds_q;
    logic    ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= bus.stb & ~ack_q;
            // write lands on the clock that raises ack
            if (bus.stb && bus.we && !ack_q) begin
                leds_q <= bus.dat_w;
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = leds_q;
    assign leds_o    = leds_q;

endmodule

/* interval_timer.sv */
module interval_timer import soc_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    wb8_if.slave bus,
    output logic irq_o
);

    logic [15:0] reload_q;
    logic [15:0] count_q;
    logic        cnt_en_q;
    logic        irq_en_q;
    logic        pending_q;
    logic        ack_q;
    logic        wr;
    logic        expire;
    timer_reg_e  reg_sel;

    // offsets alias across the 256 byte window
    assign reg_sel = timer_reg_e'(bus.adr[1:0]);
    assign wr      = bus.stb & bus.we & ~ack_q;
    assign expire  = cnt_en_q & (count_q == 16'd0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reload_q  <= '0;
            count_q   <= '0;
            cnt_en_q  <= 1'b0;
            irq_en_q  <= 1'b0;
            pending_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= bus.stb & ~ack_q;

            if (wr && reg_sel == TMR_RELOAD_LO) begin
                reload_q[7:0] <= bus.dat_w;
            end
            if (wr && reg_sel == TMR_RELOAD_HI) begin
                reload_q[15:8] <= bus.dat_w;
            end

            // control write restarts the count from reload
            if (wr && reg_sel == TMR_CTRL) begin
                cnt_en_q <= bus.dat_w[0];
                irq_en_q <= bus.dat_w[1];
                count_q  <= reload_q;
            end else if (expire) begin
                count_q <= reload_q;
            end else if (cnt_en_q) begin
                count_q <= count_q - 16'd1;
            end

            // an expiry in the same clock wins over the clear
            if (wr && reg_sel == TMR_PENDING) begin
                pending_q <= 1'b0;
            end
            if (expire) begin
                pending_q <= 1'b1;
            end
        end
    end

    // read mux, valid while ack is high since the master holds adr
    always_comb begin
        case (reg_sel)
            TMR_RELOAD_LO: bus.dat_r = reload_q[7:0];
            TMR_RELOAD_HI: bus.dat_r = reload_q[15:8];
            TMR_CTRL:      bus.dat_r = {6'b0, irq_en_q, cnt_en_q};
            default:       bus.dat_r = {7'b0, pending_q};
        endcase
    end

    assign bus.ack = ack_q;
    assign irq_o   = pending_q & irq_en_q;

endmodule

/* prng_lfsr.sv */
module prng_lfsr import soc_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    wb8_if.slave bus
);

    lfsr_t   state_q;
    lfsr_t   state_next;
    wb_dat_t dat_q;
    logic    ack_q;
    logic    access;

    assign access = bus.stb & ~ack_q;

    // one galois step, shift right and fold taps in on a carry out
    assign state_next = {1'b0, state_q[31:1]} ^ (state_q[0] ? PRNG_TAPS : '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= 32'd1;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && bus.we) begin
                // seed bytes, lsb at offset 0
                state_q[8*bus.adr[1:0] +: 8] <= bus.dat_w;
            end else if (access) begin
                state_q <= state_next;
            end
        end
    end

    // byte handed out is the one before the step
    always_ff @(posedge clk) begin
        if (access) begin
            dat_q <= state_q[7:0];
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;

endmodule

/* scratch_ram.sv */
module scratch_ram import soc_pkg::*; #(
    parameter int ADDR_BITS = 10
) (
    input  logic clk,
    input  logic reset_i,
    wb8_if.slave bus
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    wb_dat_t                mem [DEPTH];
    wb_dat_t                dat_q;
    logic                   ack_q;
    logic [ADDR_BITS-1:0]   word;

    // upper address bits ignored, contents alias every DEPTH bytes
    assign word = bus.adr[ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.stb & ~ack_q;
        end
    end

    // read first, data registered for the ack cycle
    always_ff @(posedge clk) begin
        if (bus.stb && !ack_q) begin
            if (bus.we) begin
                mem[word] <= bus.dat_w;
            end
            dat_q <= mem[word];
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;

endmodule

/* soc_top.sv */
module soc_top import soc_pkg::*; #(
    parameter int RESET_CYCLES  = 16,
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    reset_button_n_i,
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  wb_dat_t wb_dat_i,
    output wb_dat_t wb_dat_o,
    output logic    wb_ack_o,
    output wb_dat_t leds_o,
    output logic    timer_irq_o
);

    logic soc_reset;

    // one bus per device
    wb8_if ram_if ();
    wb8_if timer_if ();
    wb8_if prng_if ();
    wb8_if leds_if ();

    reset_sequencer #(
        .RESET_CYCLES(RESET_CYCLES)
    ) i_reset_sequencer (
        .clk              (clk),
        .reset_i          (reset_i),
        .reset_button_n_i (reset_button_n_i),
        .soc_reset_o      (soc_reset)
    );

    wb_decoder i_wb_decoder (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .ram_bus     (ram_if.master),
        .timer_bus   (timer_if.master),
        .prng_bus    (prng_if.master),
        .leds_bus    (leds_if.master)
    );

    scratch_ram #(
        .ADDR_BITS(RAM_ADDR_BITS)
    ) i_scratch_ram (
        .clk     (clk),
        .reset_i (soc_reset),
        .bus     (ram_if.slave)
    );

    interval_timer i_interval_timer (
        .clk     (clk),
        .reset_i (soc_reset),
        .bus     (timer_if.slave),
        .irq_o   (timer_irq_o)
    );

    prng_lfsr i_prng_lfsr (
        .clk     (clk),
        .reset_i (soc_reset),
        .bus     (prng_if.slave)
    );

    led_port i_led_port (
        .clk     (clk),
        .reset_i (soc_reset),
        .bus     (leds_if.slave),
        .leds_o  (leds_o)
    );

endmodule

/* tb_soc_top.sv */
module tb_soc_top import soc_pkg::*; ();

    localparam int RESET_CYCLES  = 16;
    localparam int RAM_ADDR_BITS = 10;
    localparam int CLK_PERIOD    = 4;
    localparam int ACK_BOUND     = 8;
    // rough cycle cost per test in the order reset ack leds ram prng timer
    localparam int TEST_CYCLES   = 2 * (RESET_CYCLES + 22) + 20 + 10 + 60 + 40 + 140;
    localparam int WATCHDOG_TIME = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic    clk;
    logic    reset_i;
    logic    reset_button_n_i;
    logic    wb_cyc_i;
    logic    wb_stb_i;
    logic    wb_we_i;
    wb_adr_t wb_adr_i;
    wb_dat_t wb_dat_i;
    wb_dat_t wb_dat_o;
    logic    wb_ack_o;
    wb_dat_t leds_o;
    logic    timer_irq_o;

    int   errors = 0;
    int   tests_run = 0;
    int   cyc_count = 0;
    int   quiet_cnt = 0;
    logic model_reset;

    soc_top #(
        .RESET_CYCLES  (RESET_CYCLES),
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // clocks since the last reset request
    // the soc stays in reset for the first RESET_CYCLES of them
    always @(posedge clk) begin
        cyc_count <= cyc_count + 1;
        if (reset_i || !reset_button_n_i) begin
            quiet_cnt <= 0;
        end else if (quiet_cnt < RESET_CYCLES) begin
            quiet_cnt <= quiet_cnt + 1;
        end
    end
    assign model_reset = (quiet_cnt < RESET_CYCLES);

    ack_after_stb: assert property (@(posedge clk) disable iff (cyc_count < 3)
        $rose(wb_cyc_i && wb_stb_i) && !model_reset |=> wb_ack_o)
    else begin
        $display("** Error at %0t: wb_ack_o expected 1 got %b", $time, $sampled(wb_ack_o));
        errors++;
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (cyc_count < 3)
        wb_ack_o |=> !wb_ack_o)
    else begin
        $display("** Error at %0t: wb_ack_o expected 0 got %b", $time, $sampled(wb_ack_o));
        errors++;
    end

    // no ack unless a strobe was seen out of reset on the clock before
    ack_needs_req: assert property (@(posedge clk) disable iff (cyc_count < 3)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i && !model_reset))
    else begin
        $display("** Error at %0t: wb_ack_o expected 0 got 1", $time);
        errors++;
    end

    leds_cleared: assert property (@(posedge clk) disable iff (cyc_count < 3)
        $past(model_reset) |-> leds_o == 8'h00)
    else begin
        $display("** Error at %0t: leds_o expected 00 got %h", $time, $sampled(leds_o));
        errors++;
    end

    irq_cleared: assert property (@(posedge clk) disable iff (cyc_count < 3)
        $past(model_reset) |-> !timer_irq_o)
    else begin
        $display("** Error at %0t: timer_irq_o expected 0 got %b", $time,
                 $sampled(timer_irq_o));
        errors++;
    end

    // one classic cycle
    // stb rises on a falling edge and drops once ack is seen
    task automatic bus_access(input wb_adr_t adr, input logic we, input wb_dat_t dat_w,
                              input int bound, output wb_dat_t dat_r, output int waited);
        int n;
        n = 0;
        dat_r = 8'h00;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat_w;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack_o && n < bound);
        if (wb_ack_o) begin
            dat_r = wb_dat_o;
        end else begin
            $display("no ack for access to %h within %0d cycles", adr, bound);
            errors++;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        waited   = n;
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        int      waited;
        bus_access(adr, 1'b1, dat, ACK_BOUND, unused, waited);
    endtask

    task automatic bus_read(input wb_adr_t adr, output wb_dat_t dat);
        int waited;
        bus_access(adr, 1'b0, 8'h00, ACK_BOUND, dat, waited);
    endtask

    task automatic check_byte(input string name, input wb_dat_t got, input wb_dat_t exp);
        assert (got == exp) else begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        $display("test %-6s finished, %0d errors", name, errors - mark);
    endtask

    function automatic lfsr_t galois_step(input lfsr_t s);
        lfsr_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ PRNG_TAPS;
        end
        return n;
    endfunction

    function automatic wb_adr_t timer_adr(input timer_reg_e r);
        return TIMER_BASE | wb_adr_t'(r);
    endfunction

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        wb_dat_t     got;
        wb_dat_t     d;
        wb_adr_t     a;
        wb_adr_t     ram_adr [8];
        wb_dat_t     ram_dat [8];
        lfsr_t       seed;
        logic [15:0] reload_n;
        int          waited;
        int          mark;

        void'($urandom(32'h57a5));
        reset_i          = 1'b1;
        reset_button_n_i = 1'b1;
        wb_cyc_i         = 1'b0;
        wb_stb_i         = 1'b0;
        wb_we_i          = 1'b0;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        // second pass restarts the stretch with a button pulse
        mark = errors;
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) begin
                // leave the leds and the timer irq set for the reset to clear
                bus_write(LEDS_BASE, wb_dat_t'($urandom) | 8'h01);
                bus_write(timer_adr(TMR_RELOAD_LO), 8'h04);
                bus_write(timer_adr(TMR_RELOAD_HI), 8'h00);
                bus_write(timer_adr(TMR_CTRL), 8'h03);
                waited = 0;
                while (!timer_irq_o && waited < 8) begin
                    @(negedge clk);
                    waited++;
                end
                check_byte("timer_irq_o", {7'b0, timer_irq_o}, 8'h01);
                @(negedge clk);
                reset_button_n_i = 1'b0;
                @(negedge clk);
                reset_button_n_i = 1'b1;
            end
            bus_access(LEDS_BASE, 1'b0, 8'h00, RESET_CYCLES + ACK_BOUND, got, waited);
            assert (waited >= RESET_CYCLES) else begin
                $display("ack came %0d cycles into a %0d cycle reset", waited, RESET_CYCLES);
                errors++;
            end
        end
        report_test("reset", mark);

        mark = errors;
        bus_read(32'h0000_0100, got);
        bus_read(timer_adr(TMR_CTRL), got);
        bus_read(PRNG_BASE, got);
        bus_read(LEDS_BASE, got);
        report_test("ack", mark);

        mark = errors;
        d = wb_dat_t'($urandom);
        bus_write(LEDS_BASE, d);
        check_byte("leds_o", leds_o, d);
        bus_read(LEDS_BASE, got);
        check_byte("wb_dat_o", got, d);
        report_test("leds", mark);

        // one address per 128 byte slice keeps the eight apart
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            ram_adr[i] = wb_adr_t'(i * 128) + wb_adr_t'($urandom % 128);
            ram_dat[i] = wb_dat_t'($urandom);
            bus_write(ram_adr[i], ram_dat[i]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(ram_adr[i], got);
            check_byte("wb_dat_o", got, ram_dat[i]);
        end
        a = wb_adr_t'($urandom % (1 << RAM_ADDR_BITS));
        d = wb_dat_t'($urandom);
        bus_write(a + wb_adr_t'(1 << RAM_ADDR_BITS), d);
        bus_read(a, got);
        check_byte("wb_dat_o", got, d);
        report_test("ram", mark);

        mark = errors;
        seed = $urandom | 32'h1;
        for (int i = 0; i < 4; i++) begin
            bus_write(PRNG_BASE | wb_adr_t'(i), seed[8*i +: 8]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(PRNG_BASE, got);
            check_byte("wb_dat_o", got, seed[7:0]);
            seed = galois_step(seed);
        end
        report_test("prng", mark);

        mark = errors;
        reload_n = 16'(12 + ($urandom % 16));
        bus_write(timer_adr(TMR_RELOAD_LO), reload_n[7:0]);
        bus_write(timer_adr(TMR_RELOAD_HI), reload_n[15:8]);
        bus_write(timer_adr(TMR_CTRL), 8'h03);
        waited = 0;
        while (!timer_irq_o && waited < int'(reload_n) + 4) begin
            @(negedge clk);
            waited++;
        end
        assert (timer_irq_o) else begin
            $display("timer_irq_o still low %0d cycles after start, reload %0d",
                     waited, reload_n);
            errors++;
        end
        bus_read(timer_adr(TMR_PENDING), got);
        check_byte("wb_dat_o", got, 8'h01);
        bus_write(timer_adr(TMR_PENDING), 8'h00);
        check_byte("timer_irq_o", {7'b0, timer_irq_o}, 8'h00);
        // counting with the interrupt masked
        bus_write(timer_adr(TMR_CTRL), 8'h01);
        repeat (int'(reload_n) + 4) begin
            @(negedge clk);
            check_byte("timer_irq_o", {7'b0, timer_irq_o}, 8'h00);
        end
        bus_read(timer_adr(TMR_PENDING), got);
        check_byte("wb_dat_o", got, 8'h01);
        bus_write(timer_adr(TMR_CTRL), 8'h00);
        report_test("timer", mark);

        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* soc_top.f */
soc_pkg.sv
wb8_if.sv
reset_sequencer.sv
wb_decoder.sv
led_port.sv
interval_timer.sv
prng_lfsr.sv
scratch_ram.sv
soc_top.sv
tb_soc_top.sv

/* run.sh */
#!/bin/sh
# build the soc testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_soc_top -o sim_soc -f soc_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1
